/* logic/ctrl_pkg.sv */
// controller types: pc select, operand forwarding select, jump kind, operand count
package ctrl_pkg;

  // register operands seen by forwarding and hazard logic
  // index 0 is operand a, the one read by the jump-register path
  parameter int unsigned N_OPS = 3;

  // next pc source for the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_t;

  // operand source in the ID stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    // alu result still in EX
    SEL_FW_EX   = 2'b01,
    // write-back result
    SEL_FW_WB   = 2'b10
  } fwd_sel_t;

  // control transfer kind seen by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    // conditional branch, resolved in EX
    BRANCH_COND = 2'b11
  } jump_t;

endpackage

/* logic/ctrl_ifs.sv */
// regmatch_if for write-back hazard info and stall_if for stall flags, with modports
`timescale 1ns/1ns

// destination register matches and write enables from the later stages
interface regmatch_if #(
  parameter int unsigned N_OPS = ctrl_pkg::N_OPS
);
  // write enables of EX, WB and the EX alu forwarding path
  logic             we_ex;
  logic             we_wb;
  logic             alu_we_fw;
  // one bit per operand, set when that operand names the pending destination
  logic [N_OPS-1:0] match_ex;
  logic [N_OPS-1:0] match_wb;
  logic [N_OPS-1:0] match_alu;

  // producer side, fed from the pipeline
  modport src (
    output we_ex, we_wb, alu_we_fw, match_ex, match_wb, match_alu
  );

  // consumers: forwarding and hazard logic
  modport dst (
    input  we_ex, we_wb, alu_we_fw, match_ex, match_wb, match_alu
  );
endinterface

// stall flags from the hazard logic
interface stall_if;
  logic load_stall;
  logic csr_stall;
  logic jr_stall;
  // keep the ID instruction from writing anything
  logic deassert_we;

  modport src (output load_stall, csr_stall, jr_stall, deassert_we);

  // the fsm only holds a jump back while its target register is pending
  modport fsm (input jr_stall);
endinterface

/* logic/ctrl_fsm.sv */
// main control fsm: state register, pc steering, stage halts, interrupt acknowledge
`timescale 1ns/1ns

module ctrl_fsm (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              fetch_enable_i,
  input  logic              instr_valid_i,
  input  logic              id_ready_i,
  input  logic              ex_valid_i,
  input  logic              mret_insn_i,
  input  logic              pipe_flush_i,
  input  logic              branch_taken_ex_i,
  input  ctrl_pkg::jump_t   jump_in_dec_i,
  input  logic              irq_i,
  stall_if.fsm              stall_fsm,
  output logic              ctrl_busy_o,
  output logic              is_decoding_o,
  output logic              instr_req_o,
  output logic              pc_set_o,
  output ctrl_pkg::pc_mux_t pc_mux_o,
  output logic              irq_ack_o,
  output logic              halt_if_o,
  output logic              halt_id_o
);
  import ctrl_pkg::*;

  typedef enum logic [2:0] {
    RESET, BOOT_SET, SLEEP, FIRST_FETCH, DECODE, FLUSH_EX, FLUSH_WB
  } ctrl_state_t;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  // pc already redirected for the instruction sitting in ID
  logic        jump_done;
  logic        jump_done_q;
  logic        is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    // running defaults
    state_d       = state_q;
    jump_done     = jump_done_q;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = PC_BOOT;
    irq_ack_o     = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    unique case (state_q)
      // idle until the core is enabled
      RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // single cycle load of the boot address
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // nothing in ID yet, so no halt needed
        if (irq_i) begin
          pc_set_o  = 1'b1;
          pc_mux_o  = PC_EXCEPTION;
          irq_ack_o = 1'b1;
        end
      end

      DECODE: begin
        if (branch_taken_ex_i) begin
          // ID holds a wrong-path instruction, redirect and drop it
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
          if (irq_i) begin
            pc_mux_o  = PC_EXCEPTION;
            irq_ack_o = 1'b1;
            halt_id_o = 1'b1;
          end
        end else if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          if (is_jump) begin
            // target known in ID; jalr waits for its base register
            pc_mux_o = PC_JUMP;
            if (!stall_fsm.jr_stall && !jump_done_q) begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end else if (mret_insn_i) begin
            pc_mux_o = PC_ERET;
            if (!jump_done_q) begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end else if (irq_i) begin
            // instruction in ID is not issued, handler fetch starts now
            pc_set_o  = 1'b1;
            pc_mux_o  = PC_EXCEPTION;
            irq_ack_o = 1'b1;
            halt_id_o = 1'b1;
          end
          // wfi, or mret back to a disabled core
          if (pipe_flush_i || (mret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end else if (irq_i) begin
          // empty ID slot
          pc_set_o  = 1'b1;
          pc_mux_o  = PC_EXCEPTION;
          irq_ack_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // drain EX
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // one cycle for WB, then resume or sleep
      FLUSH_WB: begin
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          state_d = DECODE;
        end else begin
          halt_if_o = 1'b1;
          state_d   = SLEEP;
        end
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // woken by enable or a pending interrupt
        if (fetch_enable_i || irq_i) begin
          state_d = FIRST_FETCH;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // jump_done drops once ID accepts the instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

  // no branch prediction in IF, a taken branch flushes its own successor
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branches back to back");

  // a jump or mret held in ID redirects the pc only once
  assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_o && (pc_mux_o inside {PC_JUMP, PC_ERET}) && !id_ready_i)
    |=> !(pc_set_o && (pc_mux_o inside {PC_JUMP, PC_ERET})))
    else $error("pc redirected twice for one instruction");

endmodule

/* logic/hazard_unit.sv */
// stall detection for load-use, csr-use and jump-register hazards, write-enable deassertion
`timescale 1ns/1ns

module hazard_unit #(
  parameter int unsigned N_OPS = ctrl_pkg::N_OPS
) (
  input  logic            is_decoding_i,
  input  logic            illegal_insn_i,
  input  logic            data_req_ex_i,
  input  logic            csr_busy_i,
  input  logic            csr_access_id_i,
  input  ctrl_pkg::jump_t jump_in_dec_i,
  regmatch_if.dst         rm,
  stall_if.src            stall
);
  import ctrl_pkg::*;

  // operands whose source register is being written further down the pipe
  logic [N_OPS-1:0] ex_hit;
  logic [N_OPS-1:0] wb_hit;
  logic [N_OPS-1:0] alu_hit;

  assign ex_hit  = rm.match_ex  & {N_OPS{rm.we_ex}};
  assign wb_hit  = rm.match_wb  & {N_OPS{rm.we_wb}};
  assign alu_hit = rm.match_alu & {N_OPS{rm.alu_we_fw}};

  //////////////////////////////////////////////////////////////////////
  // stall rules
  //////////////////////////////////////////////////////////////////////

  // load data arrives only in WB, any operand waiting on it must hold
  assign stall.load_stall = data_req_ex_i & (|ex_hit);

  // coarse rule, any csr access in ID waits for the busy csr
  assign stall.csr_stall = csr_busy_i & csr_access_id_i;

  // jalr base address goes straight to the pc, no forwarding on that path
  assign stall.jr_stall = (jump_in_dec_i == BRANCH_JALR) &
                          (wb_hit[0] | ex_hit[0] | alu_hit[0]);

  // no register write from an instruction that is not really issued
  assign stall.deassert_we = ~is_decoding_i
                           | illegal_insn_i
                           | stall.load_stall
                           | stall.csr_stall
                           | stall.jr_stall;

endmodule

/* logic/fwd_unit.sv */
// operand forwarding select, EX result before WB result before register file
`timescale 1ns/1ns

module fwd_unit #(
  parameter int unsigned N_OPS = ctrl_pkg::N_OPS
) (
  regmatch_if.dst                     rm,
  output ctrl_pkg::fwd_sel_t [N_OPS-1:0] operand_fw_sel_o
);
  import ctrl_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // per operand source select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int unsigned i = 0; i < N_OPS; i++) begin
      // plain register file read
      operand_fw_sel_o[i] = SEL_REGFILE;

      // older result, about to be written back
      if (rm.we_wb && rm.match_wb[i]) begin
        operand_fw_sel_o[i] = SEL_FW_WB;
      end

      // newer result from the alu wins over WB
      if (rm.alu_we_fw && rm.match_alu[i]) begin
        operand_fw_sel_o[i] = SEL_FW_EX;
      end
    end
  end

endmodule

/* logic/core_ctrl.sv */
// core controller top: fsm, hazard unit and forwarding unit joined by regmatch_if and stall_if
`timescale 1ns/1ns

module core_ctrl #(
  parameter int unsigned N_OPS = ctrl_pkg::N_OPS
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           fetch_enable_i,
  input  logic                           instr_valid_i,
  input  logic                           id_ready_i,
  input  logic                           ex_valid_i,
  input  logic                           illegal_insn_i,
  input  logic                           mret_insn_i,
  input  logic                           pipe_flush_i,
  input  logic                           branch_taken_ex_i,
  input  ctrl_pkg::jump_t                jump_in_dec_i,
  input  logic                           irq_i,
  input  logic                           data_req_ex_i,
  input  logic                           csr_busy_i,
  input  logic                           csr_access_id_i,
  input  logic                           regfile_we_ex_i,
  input  logic                           regfile_we_wb_i,
  input  logic                           regfile_alu_we_fw_i,
  input  logic [N_OPS-1:0]               reg_d_ex_match_i,
  input  logic [N_OPS-1:0]               reg_d_wb_match_i,
  input  logic [N_OPS-1:0]               reg_d_alu_match_i,
  output logic                           ctrl_busy_o,
  output logic                           is_decoding_o,
  output logic                           instr_req_o,
  output logic                           pc_set_o,
  output ctrl_pkg::pc_mux_t              pc_mux_o,
  output logic                           irq_ack_o,
  output logic                           halt_if_o,
  output logic                           halt_id_o,
  output logic                           deassert_we_o,
  output logic                           load_stall_o,
  output logic                           csr_stall_o,
  output logic                           jr_stall_o,
  output ctrl_pkg::fwd_sel_t [N_OPS-1:0] operand_fw_sel_o
);

  regmatch_if #(.N_OPS(N_OPS)) rm_if ();
  stall_if                     st_if ();

  // decode qualifier, fsm to hazard unit
  logic is_decoding;

  //////////////////////////////////////////////////////////////////////
  // pipeline hazard info onto the bundle
  //////////////////////////////////////////////////////////////////////
  assign rm_if.we_ex     = regfile_we_ex_i;
  assign rm_if.we_wb     = regfile_we_wb_i;
  assign rm_if.alu_we_fw = regfile_alu_we_fw_i;
  assign rm_if.match_ex  = reg_d_ex_match_i;
  assign rm_if.match_wb  = reg_d_wb_match_i;
  assign rm_if.match_alu = reg_d_alu_match_i;

  ctrl_fsm fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .mret_insn_i       (mret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .irq_i             (irq_i),
    .stall_fsm         (st_if.fsm),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .irq_ack_o         (irq_ack_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  hazard_unit #(.N_OPS(N_OPS)) hazard_i (
    .is_decoding_i   (is_decoding),
    .illegal_insn_i  (illegal_insn_i),
    .data_req_ex_i   (data_req_ex_i),
    .csr_busy_i      (csr_busy_i),
    .csr_access_id_i (csr_access_id_i),
    .jump_in_dec_i   (jump_in_dec_i),
    .rm              (rm_if.dst),
    .stall           (st_if.src)
  );

  fwd_unit #(.N_OPS(N_OPS)) fwd_i (
    .rm               (rm_if.dst),
    .operand_fw_sel_o (operand_fw_sel_o)
  );

  // stall flags out to the pipeline
  assign is_decoding_o = is_decoding;
  assign deassert_we_o = st_if.deassert_we;
  assign load_stall_o  = st_if.load_stall;
  assign csr_stall_o   = st_if.csr_stall;
  assign jr_stall_o    = st_if.jr_stall;

endmodule

/* bench/tb_vectors.svh */
// vector table for tb_core_ctrl: rows of dut inputs with the expected outputs
// in:  fe iv ir ev il mr pf _ br _ jump _ irq dreq csr_busy csr_acc _ we ex wb alu
//      _ match ex _ match wb _ match alu, one bit per operand 2 1 0
// out: pc_set _ pc_mux _ ack halt_if halt_id dec req dwe _ load csr jr _ fw op2 op1 op0
// jump 01 jal, 10 jalr; fw 00 regfile, 01 ex, 10 wb
localparam int N_ROWS = 28;

row_t vec [N_ROWS];

task automatic load_vectors();
  // reset, boot pulse, first fetch, decode
  vec[0]  = {26'b0000000_0_00_0000_000_000_000_000, 19'b0_000_000001_000_000000};
  vec[1]  = {26'b1000000_0_00_0000_000_000_000_000, 19'b0_000_000001_000_000000};
  vec[2]  = {26'b1000000_0_00_0000_000_000_000_000, 19'b1_000_000011_000_000000};
  vec[3]  = {26'b1000000_0_00_0000_000_000_000_000, 19'b0_000_000011_000_000000};
  vec[4]  = {26'b1010000_0_00_0000_000_000_000_000, 19'b0_000_000011_000_000000};
  vec[5]  = {26'b1110000_0_00_0000_000_000_000_000, 19'b0_000_000110_000_000000};
  // forwarding, ex over wb, alu match ignored without its write enable
  vec[6]  = {26'b1110000_0_00_0000_011_000_011_110, 19'b0_000_000110_000_010110};
  vec[7]  = {26'b1110000_0_00_0000_010_000_111_111, 19'b0_000_000110_000_101010};
  // load-use, csr busy, illegal instruction
  vec[8]  = {26'b1110000_0_00_0100_100_100_000_000, 19'b0_000_000111_100_000000};
  vec[9]  = {26'b1110000_0_00_0011_000_000_000_000, 19'b0_000_000111_010_000000};
  vec[10] = {26'b1110100_0_00_0000_000_000_000_000, 19'b0_000_000111_000_000000};
  // jal held in ID sets the pc once
  vec[11] = {26'b1100000_0_01_0000_000_000_000_000, 19'b1_010_000110_000_000000};
  vec[12] = {26'b1100000_0_01_0000_000_000_000_000, 19'b0_000_000110_000_000000};
  vec[13] = {26'b1110000_0_01_0000_000_000_000_000, 19'b0_000_000110_000_000000};
  // jalr waits for its base register
  vec[14] = {26'b1100000_0_10_0000_010_000_001_000, 19'b0_000_000111_001_000010};
  vec[15] = {26'b1100000_0_10_0000_000_000_000_000, 19'b1_010_000110_000_000000};
  vec[16] = {26'b1110000_0_00_0000_000_000_000_000, 19'b0_000_000110_000_000000};
  // taken branch, then interrupt in decode
  vec[17] = {26'b1110000_1_00_0000_000_000_000_000, 19'b1_011_000011_000_000000};
  vec[18] = {26'b1110000_0_00_1000_000_000_000_000, 19'b1_100_101110_000_000000};
  // flush with fetch disabled, drain, sleep
  vec[19] = {26'b0110001_0_00_0000_000_000_000_000, 19'b0_000_011110_000_000000};
  vec[20] = {26'b0000000_0_00_0000_000_000_000_000, 19'b0_000_011011_000_000000};
  vec[21] = {26'b0001000_0_00_0000_000_000_000_000, 19'b0_000_011011_000_000000};
  vec[22] = {26'b0000000_0_00_0000_000_000_000_000, 19'b0_000_011011_000_000000};
  vec[23] = {26'b0000000_0_00_0000_000_000_000_000, 19'b0_000_011001_000_000000};
  // interrupt wakes the core into first fetch
  vec[24] = {26'b0000000_0_00_1000_000_000_000_000, 19'b0_000_011001_000_000000};
  vec[25] = {26'b0000000_0_00_1000_000_000_000_000, 19'b1_100_100011_000_000000};
  vec[26] = {26'b1010000_0_00_0000_000_000_000_000, 19'b0_000_000011_000_000000};
  vec[27] = {26'b1110000_0_00_0000_000_000_000_000, 19'b0_000_000110_000_000000};
endtask

/* bench/tb_core_ctrl.sv */
// testbench for core_ctrl: clock, reset, vector table loop, output checks, timeout
`timescale 1ns/1ns

module tb_core_ctrl;
  import ctrl_pkg::*;

  // one table row, dut inputs first and expected outputs after
  typedef struct packed {
    logic       fe, iv, ir, ev, il, mr, pf;
    logic       br;
    logic [1:0] jmp;
    logic       irq, dreq, cbusy, cacc;
    // write enables of ex, wb and the alu path
    logic [2:0] we;
    logic [2:0] m_ex, m_wb, m_alu;
    logic       pc_set;
    logic [2:0] pc_mux;
    logic       ack, hif, hid, dec, req, dwe;
    // load, csr and jr stall
    logic [2:0] stl;
    // selects of operand 2, 1, 0
    logic [5:0] fw;
  } row_t;

  `include "tb_vectors.svh"

  // reset, table and some slack
  localparam int CYCLE_LIMIT = 16 + N_ROWS + 20;

  logic                 clk;
  logic                 rst_n;
  logic                 fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i;
  logic                 illegal_insn_i, mret_insn_i, pipe_flush_i, branch_taken_ex_i;
  jump_t                jump_in_dec_i;
  logic                 irq_i, data_req_ex_i, csr_busy_i, csr_access_id_i;
  logic                 regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic [N_OPS-1:0]     reg_d_ex_match_i, reg_d_wb_match_i, reg_d_alu_match_i;
  logic                 ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o;
  pc_mux_t              pc_mux_o;
  logic                 irq_ack_o, halt_if_o, halt_id_o;
  logic                 deassert_we_o, load_stall_o, csr_stall_o, jr_stall_o;
  fwd_sel_t [N_OPS-1:0] operand_fw_sel_o;
  int                   cycles = 0;

  core_ctrl #(.N_OPS(N_OPS)) dut_i (.*);

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // run limit
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the table did not finish within %0d clock cycles", cycles);
      $display("test failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "output check failed");
    end
  endtask

  task automatic apply_row(input row_t r);
    fetch_enable_i      = r.fe;
    instr_valid_i       = r.iv;
    id_ready_i          = r.ir;
    ex_valid_i          = r.ev;
    illegal_insn_i      = r.il;
    mret_insn_i         = r.mr;
    pipe_flush_i        = r.pf;
    branch_taken_ex_i   = r.br;
    jump_in_dec_i       = jump_t'(r.jmp);
    irq_i               = r.irq;
    data_req_ex_i       = r.dreq;
    csr_busy_i          = r.cbusy;
    csr_access_id_i     = r.cacc;
    regfile_we_ex_i     = r.we[2];
    regfile_we_wb_i     = r.we[1];
    regfile_alu_we_fw_i = r.we[0];
    reg_d_ex_match_i    = r.m_ex;
    reg_d_wb_match_i    = r.m_wb;
    reg_d_alu_match_i   = r.m_alu;
  endtask

  task automatic check_row(input row_t r);
    compare_value("pc_set_o", 32'(pc_set_o), 32'(r.pc_set));
    // the select is only looked at while the pc is set
    if (r.pc_set) begin
      compare_value("pc_mux_o", 32'(pc_mux_o), 32'(r.pc_mux));
    end
    compare_value("irq_ack_o", 32'(irq_ack_o), 32'(r.ack));
    compare_value("halt_if_o", 32'(halt_if_o), 32'(r.hif));
    compare_value("halt_id_o", 32'(halt_id_o), 32'(r.hid));
    compare_value("is_decoding_o", 32'(is_decoding_o), 32'(r.dec));
    compare_value("instr_req_o", 32'(instr_req_o), 32'(r.req));
    // busy and fetch request both drop in reset and sleep only
    compare_value("ctrl_busy_o", 32'(ctrl_busy_o), 32'(r.req));
    compare_value("deassert_we_o", 32'(deassert_we_o), 32'(r.dwe));
    compare_value("load_stall_o", 32'(load_stall_o), 32'(r.stl[2]));
    compare_value("csr_stall_o", 32'(csr_stall_o), 32'(r.stl[1]));
    compare_value("jr_stall_o", 32'(jr_stall_o), 32'(r.stl[0]));
    compare_value("operand_fw_sel_o", 32'(operand_fw_sel_o), 32'(r.fw));
  endtask

  //////////////////////////////////////////////////////////////////////
  // reset, then one table row per cycle
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    apply_row('0);
    load_vectors();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      @(negedge clk);
      apply_row(vec[i]);
      // half way to the rising edge, outputs have settled
      #5;
      check_row(vec[i]);
    end
    $display("test passed");
    $finish;
  end

endmodule

/* src.f */
+incdir+bench
logic/ctrl_pkg.sv
logic/ctrl_ifs.sv
logic/ctrl_fsm.sv
logic/hazard_unit.sv
logic/fwd_unit.sv
logic/core_ctrl.sv
bench/tb_core_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# build the core_ctrl testbench with Verilator, run it, and search the log for the verdict
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_core_ctrl -o tb_core_ctrl
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_core_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
